//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction word width
`define CPU_DATA_W 16

// architectural registers incl. hardwired r0
`define CPU_REG_COUNT 16

`define CPU_IMEM_DEPTH 256 // instruction words
`define CPU_DMEM_DEPTH 256 // data words

`endif

//--- cpuIsaPkg.sv
package cpuIsaPkg;

	// opcode field in bits [15:12]
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LLB = 4'hA,
		OP_LHB = 4'hB,
		OP_B   = 4'hC,
		OP_BR  = 4'hD,
		OP_HLT = 4'hF
	} opcodeT;

	// rt doubles as shamt or low imm bits
	typedef struct packed {
		opcodeT     opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} instrT;

	// branch cond sits in rd[3:1]
	typedef enum logic [2:0] {
		COND_NE     = 3'b000, // z clear
		COND_EQ     = 3'b001, // z set
		COND_GT     = 3'b010, // z and n clear
		COND_LT     = 3'b011, // n set
		COND_GE     = 3'b100, // z set or n clear
		COND_LE     = 3'b101, // n or z set
		COND_OVF    = 3'b110, // v set
		COND_ALWAYS = 3'b111
	} condT;

endpackage

//--- cpuCtrlPkg.sv
package cpuCtrlPkg;

	// operations the alu knows
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_SLL,
		ALU_SRA,
		ALU_ROR,
		ALU_PASS_B // operand b straight through
	} aluOpT;

	// what lands in rd
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,       // load data
		WB_LOW_BYTE,  // llb merge
		WB_HIGH_BYTE  // lhb merge
	} wbSrcT;

	// next pc select
	typedef enum logic [1:0] {
		PC_SEQ,    // pc + 2
		PC_BRANCH, // pc + 2 + offset
		PC_REG,    // register target
		PC_HOLD    // halted
	} pcSrcT;

endpackage

//--- alu.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module alu
	import cpuCtrlPkg::*;
(
	input  logic [`CPU_DATA_W-1:0]         a,     // rs operand
	input  logic [`CPU_DATA_W-1:0]         b,     // rt or imm
	input  aluOpT                          op,
	input  logic [$clog2(`CPU_DATA_W)-1:0] shamt, // from rt field
	output logic [`CPU_DATA_W-1:0]         result,
	output logic                           zero,
	output logic                           neg,
	output logic                           ovf
);

	localparam int W = `CPU_DATA_W;

	logic [W-1:0]   sum;     // a + b wrapped
	logic [W-1:0]   diff;    // a - b wrapped
	logic [2*W-1:0] rotWide; // doubled word for rotate
	logic           addOvf;
	logic           subOvf;

	assign sum  = a + b;
	assign diff = a - b;
	assign rotWide = {a, a} >> shamt;

	// same signs in, other sign out
	assign addOvf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	// signs differ and result flips away from a
	assign subOvf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

	always_comb begin
		ovf = 1'b0; // only add and sub overflow
		case (op)
			ALU_ADD: begin
				result = sum;
				ovf    = addOvf;
			end
			ALU_SUB: begin
				result = diff;
				ovf    = subOvf;
			end
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << shamt; // zero fill
			ALU_SRA: result = $unsigned($signed(a) >>> shamt); // sign fill
			ALU_ROR: result = rotWide[W-1:0]; // low half of shifted pair
			ALU_PASS_B: result = b;
			default: result = b;
		endcase
	end

	assign zero = (result == '0);
	assign neg  = result[W-1]; // msb as sign

endmodule

//--- registerFile.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module registerFile (
	input  logic                              clk,
	input  logic                              rstN,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] srcReg1,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] srcReg2,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] dstReg,
	input  logic                              writeEn,
	input  logic [`CPU_DATA_W-1:0]            dstData,
	output logic [`CPU_DATA_W-1:0]            srcData1,
	output logic [`CPU_DATA_W-1:0]            srcData2
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT]; // r0 slot never written

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0; // all regs clear on reset
			end
		end else if (writeEn && (dstReg != '0)) begin // r0 writes dropped
			regs[dstReg] <= dstData;
		end
	end

	// async reads, r0 forced to zero
	assign srcData1 = (srcReg1 == '0) ? '0 : regs[srcReg1];
	assign srcData2 = (srcReg2 == '0) ? '0 : regs[srcReg2];

endmodule

//--- controlUnit.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module controlUnit
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	input  instrT                  instr,
	input  logic                   zIn,      // live alu flags
	input  logic                   nIn,
	input  logic                   vIn,
	output logic [3:0]             srcReg1,
	output logic [3:0]             srcReg2,
	output logic [3:0]             dstReg,
	output logic                   regWrite,
	output aluOpT                  aluOp,
	output logic                   aluSrc,   // 1 picks imm as operand b
	output logic [`CPU_DATA_W-1:0] imm,
	output logic                   memWrite,
	output wbSrcT                  wbSrc,
	output pcSrcT                  pcSrc,
	output logic                   halt
);

	localparam int W = `CPU_DATA_W;

	logic         zQ, nQ, vQ; // stored flags
	logic         haltQ;      // sticky halt
	logic         isHlt;
	logic         taken;      // branch cond met
	condT         cond;
	logic [W-1:0] memOff;     // signed 4b offset times two
	logic [W-1:0] brOff;      // signed 9b offset times two
	logic [W-1:0] byteImm;    // 8b for llb and lhb

	assign isHlt   = (instr.opcode == OP_HLT);
	assign halt    = haltQ | isHlt; // high in the fetch cycle already
	assign cond    = condT'(instr.rd[3:1]);
	assign memOff  = {{(W-5){instr.rt[3]}}, instr.rt, 1'b0};
	assign brOff   = {{(W-10){instr.rd[0]}}, instr.rd[0], instr.rs, instr.rt, 1'b0};
	assign byteImm = {{(W-8){1'b0}}, instr.rs, instr.rt};

	// condition against flags from earlier instrs
	always_comb begin
		case (cond)
			COND_NE:     taken = ~zQ;
			COND_EQ:     taken = zQ;
			COND_GT:     taken = ~zQ & ~nQ;
			COND_LT:     taken = nQ;
			COND_GE:     taken = zQ | ~nQ;
			COND_LE:     taken = nQ | zQ;
			COND_OVF:    taken = vQ;
			COND_ALWAYS: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	always_comb begin
		srcReg1  = instr.rs;
		srcReg2  = instr.rt;
		dstReg   = instr.rd;
		regWrite = 1'b0;
		aluOp    = ALU_PASS_B;
		aluSrc   = 1'b0;
		imm      = '0;
		memWrite = 1'b0;
		wbSrc    = WB_ALU;
		pcSrc    = PC_SEQ;
		case (instr.opcode)
			OP_ADD: begin
				regWrite = 1'b1;
				aluOp    = ALU_ADD;
			end
			OP_SUB: begin
				regWrite = 1'b1;
				aluOp    = ALU_SUB;
			end
			OP_XOR: begin
				regWrite = 1'b1;
				aluOp    = ALU_XOR;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				regWrite = 1'b1; // shamt taken from rt field
				aluOp    = (instr.opcode == OP_SLL) ? ALU_SLL :
					(instr.opcode == OP_SRA) ? ALU_SRA : ALU_ROR;
			end
			OP_LW: begin
				regWrite = 1'b1;
				aluOp    = ALU_ADD; // rs + offset
				aluSrc   = 1'b1;
				imm      = memOff;
				wbSrc    = WB_MEM;
			end
			OP_SW: begin
				srcReg2  = instr.rd; // store data comes from rd
				aluOp    = ALU_ADD;
				aluSrc   = 1'b1;
				imm      = memOff;
				memWrite = 1'b1;
			end
			OP_LLB, OP_LHB: begin
				srcReg2  = instr.rd; // old rd for the kept byte
				regWrite = 1'b1;
				imm      = byteImm;
				wbSrc    = (instr.opcode == OP_LLB) ? WB_LOW_BYTE : WB_HIGH_BYTE;
			end
			OP_B: begin
				imm   = brOff;
				pcSrc = taken ? PC_BRANCH : PC_SEQ;
			end
			OP_BR: pcSrc = taken ? PC_REG : PC_SEQ; // target in rs
			OP_HLT: pcSrc = PC_HOLD;
			default: ; // unused encodings fall through as nop
		endcase
		if (haltQ) begin
			regWrite = 1'b0; // frozen until reset
			memWrite = 1'b0;
			pcSrc    = PC_HOLD;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			zQ    <= 1'b0;
			nQ    <= 1'b0;
			vQ    <= 1'b0;
			haltQ <= 1'b0;
		end else begin
			if (isHlt) begin
				haltQ <= 1'b1;
			end
			case (instr.opcode)
				OP_ADD, OP_SUB: begin // arithmetic sets all three
					zQ <= zIn;
					nQ <= nIn;
					vQ <= vIn;
				end
				OP_XOR, OP_SLL, OP_SRA, OP_ROR: zQ <= zIn; // z only
				default: ;
			endcase
		end
	end

endmodule

//--- syncMemory.sv
`timescale 1ns/100ps

module syncMemory #(
	parameter type      payloadT = logic [15:0],
	parameter int       DEPTH    = 256,
	localparam int      AW       = $clog2(DEPTH)
) (
	input  logic    clk,
	input  logic    writeEn,
	input  logic [AW-1:0] writeAddr, // word index
	input  payloadT writeData,
	input  logic [AW-1:0] readAddrA,
	input  logic [AW-1:0] readAddrB,
	output payloadT readDataA,
	output payloadT readDataB
);

	payloadT mem [DEPTH]; // contents undefined until written

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[writeAddr] <= writeData;
		end
	end

	// both reads combinational
	assign readDataA = mem[readAddrA];
	assign readDataB = mem[readAddrB];

endmodule

//--- cpu.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu
	import cpuIsaPkg::*, cpuCtrlPkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   loadEn,   // imem fill, honored in reset only
	input  logic [`CPU_DATA_W-1:0] loadAddr, // byte address
	input  logic [`CPU_DATA_W-1:0] loadData,
	input  logic [`CPU_DATA_W-1:0] peekAddr, // byte address into dmem
	output logic [`CPU_DATA_W-1:0] peekData,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic                   hlt
);

	localparam int W       = `CPU_DATA_W;
	localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

	instrT        instr;               // current instruction
	logic [W-1:0] pcPlus2, pcBranch, pcNext;
	logic [W-1:0] srcData1, srcData2;  // register read data
	logic [W-1:0] aluB, aluResult;
	logic [W-1:0] memData, wbData, imm;
	logic [3:0]   srcReg1, srcReg2, dstReg;
	logic         regWrite, aluSrc, memWrite;
	logic         zFlag, nFlag, vFlag; // live alu flags
	aluOpT        aluOp;
	wbSrcT        wbSrc;
	pcSrcT        pcSrc;

	assign pcPlus2  = pc + W'(2);
	assign pcBranch = pcPlus2 + imm; // imm already scaled by two

	always_comb begin
		case (pcSrc)
			PC_SEQ:    pcNext = pcPlus2;
			PC_BRANCH: pcNext = pcBranch;
			PC_REG:    pcNext = srcData1; // br target from rs
			PC_HOLD:   pcNext = pc;
			default:   pcNext = pcPlus2;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0; // restart at address 0
		end else begin
			pc <= pcNext;
		end
	end

	syncMemory #(.payloadT(instrT), .DEPTH(`CPU_IMEM_DEPTH)) iInstrMem (
		.clk       (clk),
		.writeEn   (loadEn & ~rstN), // loader owns imem while reset held
		.writeAddr (loadAddr[IMEM_AW:1]),
		.writeData (instrT'(loadData)),
		.readAddrA (pc[IMEM_AW:1]),
		.readAddrB ('0),
		.readDataA (instr),
		.readDataB ()
	);

	registerFile iRegFile (
		.clk      (clk),
		.rstN     (rstN),
		.srcReg1  (srcReg1),
		.srcReg2  (srcReg2),
		.dstReg   (dstReg),
		.writeEn  (regWrite),
		.dstData  (wbData),
		.srcData1 (srcData1),
		.srcData2 (srcData2)
	);

	assign aluB = aluSrc ? imm : srcData2;

	alu iAlu (
		.a      (srcData1),
		.b      (aluB),
		.op     (aluOp),
		.shamt  (instr.rt), // shift count lives in rt
		.result (aluResult),
		.zero   (zFlag),
		.neg    (nFlag),
		.ovf    (vFlag)
	);

	controlUnit iCtrl (
		.clk      (clk),
		.rstN     (rstN),
		.instr    (instr),
		.zIn      (zFlag),
		.nIn      (nFlag),
		.vIn      (vFlag),
		.srcReg1  (srcReg1),
		.srcReg2  (srcReg2),
		.dstReg   (dstReg),
		.regWrite (regWrite),
		.aluOp    (aluOp),
		.aluSrc   (aluSrc),
		.imm      (imm),
		.memWrite (memWrite),
		.wbSrc    (wbSrc),
		.pcSrc    (pcSrc),
		.halt     (hlt)
	);

	syncMemory #(.payloadT(logic [W-1:0]), .DEPTH(`CPU_DMEM_DEPTH)) iDataMem (
		.clk       (clk),
		.writeEn   (memWrite & rstN), // stores only once out of reset
		.writeAddr (aluResult[DMEM_AW:1]),
		.writeData (srcData2),        // rd value for sw
		.readAddrA (aluResult[DMEM_AW:1]),
		.readAddrB (peekAddr[DMEM_AW:1]), // inspection port
		.readDataA (memData),
		.readDataB (peekData)
	);

	always_comb begin
		case (wbSrc)
			WB_ALU:       wbData = aluResult;
			WB_MEM:       wbData = memData;
			WB_LOW_BYTE:  wbData = {srcData2[W-1:8], imm[7:0]}; // keep high byte
			WB_HIGH_BYTE: wbData = {imm[7:0], srcData2[7:0]};   // keep low byte
			default:      wbData = aluResult;
		endcase
	end

endmodule

//--- cpu_chk.sv
`timescale 1ns/100ps

module cpu_chk (
	input logic        clk,
	input logic        rstN,
	input logic        hlt,
	input logic [15:0] pc,
	input logic [15:0] r0Value
);

	// halted core stays halted with a frozen pc
	haltSticky: assert property (@(posedge clk) disable iff (!rstN)
		hlt |=> (hlt && $stable(pc)))
		else $error("hlt dropped or pc moved while halted");

	pcEven: assert property (@(posedge clk) disable iff (!rstN)
		pc[0] == 1'b0)
		else $error("pc is odd");

	// r0 storage never takes a write
	regZero: assert property (@(posedge clk) disable iff (!rstN)
		r0Value == 16'h0000)
		else $error("register 0 holds nonzero");

endmodule

bind cpu cpu_chk iChk (
	.clk     (clk),
	.rstN    (rstN),
	.hlt     (hlt),
	.pc      (pc),
	.r0Value (iRegFile.regs[0])
);

//--- tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu
	import cpuIsaPkg::*;
;

	localparam int TIMEOUT_CYCLES = 2000; // all programs plus resets, with margin

	logic        clk, rstN, loadEn, hlt;
	logic [15:0] loadAddr, loadData, peekAddr, peekData, pc;
	logic [15:0] prog [$]; // program being assembled
	integer      seed = 32'h75a4;
	int          cycleCount = 0;

	cpu i_cpu (.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .peekAddr(peekAddr), .peekData(peekData), .pc(pc), .hlt(hlt));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the core never halted within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "run stopped on first mismatch");
		end
	endtask

	function automatic logic [15:0] enc(opcodeT op, logic [3:0] rd, logic [3:0] rs, logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	task automatic emit(input logic [15:0] word);
		prog.push_back(word);
	endtask

	// llb then lhb builds any 16b constant
	task automatic loadConst(input logic [3:0] rd, input logic [15:0] value);
		emit(enc(OP_LLB, rd, value[7:4], value[3:0]));
		emit(enc(OP_LHB, rd, value[15:12], value[11:8]));
	endtask

	task automatic emitMem(input opcodeT op, input logic [3:0] rd, input logic [3:0] rs,
		input int off);
		emit(enc(op, rd, rs, off[3:0])); // signed word offset
	endtask

	// load through the port under reset, then run to halt
	task automatic runProgram();
		@(posedge clk);
		#2;
		rstN = 1'b0;
		#1;
		checkValue("pc in reset", pc, 16'h0000);
		foreach (prog[i]) begin
			loadEn   = 1'b1;
			loadAddr = 16'(i * 2);
			loadData = prog[i];
			@(posedge clk);
			#2;
		end
		loadEn = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rstN = 1'b1;
		do begin
			@(posedge clk);
			#2;
		end while (hlt !== 1'b1);
	endtask

	task automatic checkMem(input string name, input logic [15:0] addr, input logic [15:0] exp);
		peekAddr = addr;
		#1;
		checkValue(name, peekData, exp);
	endtask

	function automatic logic [15:0] sllModel(logic [15:0] a, int s);
		logic [15:0] r;
		r = a;
		repeat (s) r = {r[14:0], 1'b0};
		return r;
	endfunction

	function automatic logic [15:0] sraModel(logic [15:0] a, int s);
		logic [15:0] r;
		r = a;
		repeat (s) r = {r[15], r[15:1]}; // sign bit copied in
		return r;
	endfunction

	function automatic logic [15:0] rorModel(logic [15:0] a, int s);
		logic [15:0] r;
		r = a;
		repeat (s) r = {r[0], r[15:1]};
		return r;
	endfunction

	task automatic testArith();
		logic [15:0] a, b;
		a = $random(seed);
		b = $random(seed);
		prog.delete();
		loadConst(1, a);
		loadConst(2, b);
		loadConst(6, 16'h0040);
		emit(enc(OP_ADD, 3, 1, 2));
		emit(enc(OP_SUB, 4, 1, 2));
		emit(enc(OP_XOR, 5, 1, 2));
		emitMem(OP_SW, 3, 6, 0);
		emitMem(OP_SW, 4, 6, 1);
		emitMem(OP_SW, 5, 6, 2);
		emit(enc(OP_HLT, 0, 0, 0));
		runProgram();
		checkMem("add result", 16'h0040, 16'(a + b)); // wraps at 16 bits
		checkMem("sub result", 16'h0042, 16'(a - b));
		checkMem("xor result", 16'h0044, a ^ b);
	endtask

	task automatic testShifts();
		logic [15:0] a;
		int          shamts [4];
		int          slot;
		a = $random(seed);
		a[15] = 1'b1; // make sra fill visible
		shamts = '{0, 3, 8, 15};
		prog.delete();
		loadConst(1, a);
		loadConst(6, 16'h0060);
		for (int i = 0; i < 4; i++) begin
			emit(enc(OP_SLL, 2, 1, shamts[i][3:0]));
			emit(enc(OP_SRA, 3, 1, shamts[i][3:0]));
			emit(enc(OP_ROR, 4, 1, shamts[i][3:0]));
			for (int j = 0; j < 3; j++) begin
				emitMem(OP_SW, 4'(2 + j), 6, i * 3 + j - 6);
			end
		end
		emit(enc(OP_HLT, 0, 0, 0));
		runProgram();
		for (int i = 0; i < 4; i++) begin
			slot = i * 3 - 6;
			checkMem("sll result", 16'(16'h0060 + 2 * slot), sllModel(a, shamts[i]));
			checkMem("sra result", 16'(16'h0062 + 2 * slot), sraModel(a, shamts[i]));
			checkMem("ror result", 16'(16'h0064 + 2 * slot), rorModel(a, shamts[i]));
		end
	endtask

	task automatic testBytesMem();
		logic [15:0] a;
		logic [7:0]  lo, hi;
		a  = $random(seed);
		lo = $random(seed);
		hi = $random(seed);
		prog.delete();
		loadConst(1, a);
		loadConst(6, 16'h0060);
		emit(enc(OP_LLB, 1, lo[7:4], lo[3:0]));
		emitMem(OP_SW, 1, 6, -3);         // 0x5a
		emit(enc(OP_LHB, 1, hi[7:4], hi[3:0]));
		emitMem(OP_SW, 1, 6, 4);          // 0x68
		emitMem(OP_LW, 8, 6, -3);
		emitMem(OP_SW, 8, 6, 7);          // 0x6e
		emit(enc(OP_HLT, 0, 0, 0));
		runProgram();
		checkMem("llb keeps high byte", 16'h005A, {a[15:8], lo});
		checkMem("lhb keeps low byte", 16'h0068, {hi, lo});
		checkMem("lw after sw", 16'h006E, {a[15:8], lo});
	endtask

	task automatic testBranches();
		logic [15:0] xs [5], ys [5], res, exp [16];
		bit          isSub [5];
		bit          z, n, v, taken;
		int          full, p, n0;
		int          pick [16];
		condT        c;
		xs = '{16'd5, 16'd3, 16'd7, 16'h7FFF, 16'h0};
		ys = '{16'd5, 16'd7, 16'd3, 16'h0001, 16'h0};
		isSub = '{1, 1, 1, 0, 0};
		pick = '{0, 1, 3, 0, 2, 1, 1, 0, 0, 1, 2, 3, 2, 3, 4, 1}; // taken and skipped per cond
		xs[4] = $random(seed);
		ys[4] = $random(seed);
		prog.delete();
		loadConst(6, 16'h0080);
		loadConst(7, 16'h00A0);
		loadConst(9, 16'h00A5); // marker
		for (int s = 0; s < 16; s++) begin
			c = condT'(s / 2);
			p = pick[s];
			loadConst(1, xs[p]);
			loadConst(2, ys[p]);
			emit(enc(isSub[p] ? OP_SUB : OP_ADD, 0, 1, 2)); // flags only
			emitMem(OP_SW, 0, 6, s - 8);
			emit({OP_B, c, 1'b0, 8'h01}); // skip next word if taken
			emitMem(OP_SW, 9, 6, s - 8);
			full = isSub[p] ? ($signed(xs[p]) - $signed(ys[p])) :
				($signed(xs[p]) + $signed(ys[p]));
			res = 16'(full);
			z = (res == 16'h0);
			n = res[15];
			v = (full > 32767) || (full < -32768);
			case (c)
				COND_NE: taken = !z;
				COND_EQ: taken = z;
				COND_GT: taken = !z && !n;
				COND_LT: taken = n;
				COND_GE: taken = z || !n;
				COND_LE: taken = n || z;
				COND_OVF: taken = v;
				default: taken = 1'b1;
			endcase
			exp[s] = taken ? 16'h0000 : 16'h00A5;
		end
		emitMem(OP_SW, 0, 7, 0);
		n0 = prog.size();
		loadConst(10, 16'((n0 + 4) * 2)); // target is the hlt word
		emit(enc(OP_BR, 4'hE, 10, 0));
		emitMem(OP_SW, 9, 7, 0);
		emit(enc(OP_HLT, 0, 0, 0));
		runProgram();
		for (int s = 0; s < 16; s++) begin
			checkMem($sformatf("branch marker %0d", s), 16'(16'h0080 + 2 * (s - 8)), exp[s]);
		end
		checkMem("br skipped store", 16'h00A0, 16'h0000);
	endtask

	task automatic testHaltReset();
		logic [15:0] hltAddr;
		prog.delete();
		loadConst(6, 16'h0040);
		loadConst(9, 16'h1234);
		emit(enc(OP_LLB, 0, 4'hA, 4'h5)); // r0 write dropped
		emitMem(OP_SW, 0, 6, 0);
		emit(enc(OP_ADD, 0, 9, 9));
		emitMem(OP_SW, 0, 6, 1);
		hltAddr = 16'(prog.size() * 2);
		emit(enc(OP_HLT, 0, 0, 0));
		emitMem(OP_SW, 9, 6, 0); // must never run
		runProgram();
		checkValue("pc at halt", pc, hltAddr);
		repeat (3) @(posedge clk);
		#2;
		checkValue("pc held", pc, hltAddr);
		checkValue("hlt held", {15'h0, hlt}, 16'h0001);
		checkMem("r0 after llb", 16'h0040, 16'h0000);
		checkMem("r0 after add", 16'h0042, 16'h0000);
	endtask

	initial begin
		rstN     = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		peekAddr = '0;
		testArith();
		testShifts();
		testBytesMem();
		testBranches();
		testHaltReset();
		testArith(); // fresh reset restarts from address 0
		$display("All tests passed");
		$finish;
	end

endmodule

//--- project.f
+incdir+.
cpuIsaPkg.sv
cpuCtrlPkg.sv
alu.sv
registerFile.sv
controlUnit.sv
syncMemory.sv
cpu.sv
cpu_chk.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - .

sources:
  - cpuIsaPkg.sv
  - cpuCtrlPkg.sv
  - alu.sv
  - registerFile.sv
  - controlUnit.sv
  - syncMemory.sv
  - cpu.sv
  - target: simulation
    files:
      - cpu_chk.sv
      - tb_cpu.sv
